//--- hw/pvc_pkg.sv
// PVC cartridge protection coprocessor shared definitions
// Holds the 68000 address map of the work RAM and the protection ports,
// the port numbers, the common word types and the palette color union

package pvc_pkg;

	// ======================================================================
	// Word and address types
	// ======================================================================

	// One 68000 data word
	typedef logic [15:0] pvc_word_t;
	// CPU word address, byte address bit 0 is not on the bus
	typedef logic [19:1] pvc_waddr_t;
	// P2 ROM byte address
	typedef logic [23:0] pvc_p2_addr_t;
	// Word index into the work RAM
	typedef logic [11:0] pvc_ram_addr_t;
	// Port number inside the overlay window
	typedef logic [3:0]  pvc_port_t;

	// ======================================================================
	// Palette color word
	// ======================================================================

	// Neo Geo palette layout, dark bit on top and the three component LSBs below it
	typedef struct packed {
		logic       dark;
		logic       r_lsb;
		logic       g_lsb;
		logic       b_lsb;
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} pvc_color_neo_t;

	// Two 5-bit components, one in each byte, upper bits of each byte unused
	typedef struct packed {
		logic [2:0] hi_pad;
		logic [4:0] hi;
		logic [2:0] lo_pad;
		logic [4:0] lo;
	} pvc_color_pair_t;

	// The same port word seen either as a palette color or as a component pair
	typedef union packed {
		pvc_color_neo_t  neo;
		pvc_color_pair_t pair;
	} pvc_color_u;

	// ======================================================================
	// Memory map
	// ======================================================================

	// Address bits that must all be one to hit the work RAM window
	localparam int RAM_TAG_MSB  = 19;
	localparam int RAM_TAG_LSB  = 13;
	// Further bits that select the port overlay at the top of the RAM
	localparam int PORT_TAG_MSB = 12;
	localparam int PORT_TAG_LSB = 5;
	// Number of 16-bit words in the work RAM
	localparam int RAM_DEPTH    = 4096;

	// Port numbers within the overlay
	localparam pvc_port_t PORT_COLOR_IN  = 4'd0;
	localparam pvc_port_t PORT_UNPACK_BG = 4'd1;
	localparam pvc_port_t PORT_UNPACK_RS = 4'd2;
	localparam pvc_port_t PORT_PACK_GB   = 4'd4;
	localparam pvc_port_t PORT_PACK_R    = 4'd5;
	localparam pvc_port_t PORT_PACK_OUT  = 4'd6;
	localparam pvc_port_t PORT_BANK_LO   = 4'd8;
	localparam pvc_port_t PORT_BANK_HI   = 4'd9;

	// Fixed low byte that comes back with the bank low read
	localparam logic [7:0] BANK_LO_TAG = 8'hA0;

endpackage

//--- hw/pvc_work_ram.sv
// PVC work RAM
// 4 K words of 16 bits with a write enable per byte lane and a registered
// read port, old data is returned when a word is read and written together

module pvc_work_ram import pvc_pkg::*; (
	input  logic          CLK_24M,
	input  pvc_ram_addr_t ram_addr,
	input  logic [1:0]    ram_we,
	input  pvc_word_t     ram_wdata,
	output pvc_word_t     ram_rdata
);

	// ======================================================================
	// Storage array
	// ======================================================================

	// Content is undefined until the CPU has written it
	pvc_word_t mem [RAM_DEPTH];

	// Each byte lane has its own write enable, lower lane first
	always_ff @(posedge CLK_24M) begin
		if (ram_we[0])
			mem[ram_addr][7:0] <= ram_wdata[7:0];
		// Upper byte lane
		if (ram_we[1])
			mem[ram_addr][15:8] <= ram_wdata[15:8];
	end

	// ======================================================================
	// Read port
	// ======================================================================

	// Read samples the array before the write of the same edge takes effect
	always_ff @(posedge CLK_24M) begin
		ram_rdata <= mem[ram_addr];
	end

endmodule

//--- hw/pvc_bus_decode.sv
// PVC bus decoder
// Sorts each CPU access into work RAM, protection port or PROM, produces the
// RAM and port write strobes and returns read data one cycle after the request

module pvc_bus_decode import pvc_pkg::*; (
	input  logic          CLK_24M,
	input  logic          nRESET,
	input  logic          enable,
	input  pvc_waddr_t    cpu_addr,
	input  pvc_word_t     cpu_wdata,
	input  logic [1:0]    cpu_we,
	input  logic          cpu_re,
	input  pvc_word_t     prom_data,
	input  pvc_word_t     ram_rdata,
	input  pvc_word_t     unpack_bg,
	input  pvc_word_t     unpack_rs,
	input  pvc_word_t     pack_out,
	input  pvc_word_t     bank_rd_lo,
	input  pvc_word_t     bank_rd_hi,
	output pvc_word_t     cpu_rdata,
	output logic          cpu_rvalid,
	output pvc_ram_addr_t ram_addr,
	output logic [1:0]    ram_we,
	output pvc_word_t     ram_wdata,
	output logic          port_we,
	output pvc_port_t     port_no,
	output pvc_word_t     port_wdata
);

	// ======================================================================
	// Address classification
	// ======================================================================

	logic      ram_acc;
	logic      port_acc;
	logic      port_rd_hit;
	pvc_word_t port_rd_val;
	logic      sel_ram;
	pvc_word_t hold_word;

	// The whole window disappears when the cartridge chip is disabled
	assign ram_acc  = enable & (&cpu_addr[RAM_TAG_MSB:RAM_TAG_LSB]);
	assign port_acc = ram_acc & (&cpu_addr[PORT_TAG_MSB:PORT_TAG_LSB]);
	assign port_no  = cpu_addr[4:1];

	// Port writes fall through into the RAM underneath as well
	assign ram_addr   = cpu_addr[12:1];
	assign ram_we     = ram_acc ? cpu_we : 2'b00;
	assign ram_wdata  = cpu_wdata;
	assign port_we    = port_acc & (|cpu_we);
	assign port_wdata = cpu_wdata;

	// Only a few ports return their own value, the rest read as RAM
	always_comb begin
		port_rd_hit = port_acc;
		case (port_no)
			PORT_UNPACK_BG: port_rd_val = unpack_bg;
			PORT_UNPACK_RS: port_rd_val = unpack_rs;
			PORT_PACK_OUT:  port_rd_val = pack_out;
			PORT_BANK_LO:   port_rd_val = bank_rd_lo;
			PORT_BANK_HI:   port_rd_val = bank_rd_hi;
			default: begin
				port_rd_hit = 1'b0;
				port_rd_val = ram_rdata;
			end
		endcase
	end

	// ======================================================================
	// Read pipeline
	// ======================================================================

	// Valid flag and source select follow the request by one cycle
	always_ff @(posedge CLK_24M) begin
		if (!nRESET) begin
			cpu_rvalid <= 1'b0;
			sel_ram    <= 1'b0;
		end else begin
			cpu_rvalid <= cpu_re;
			if (cpu_re)
				sel_ram <= ram_acc & ~port_rd_hit;
		end
	end

	// Port and PROM values are sampled on the request edge, before any write lands
	always_ff @(posedge CLK_24M) begin
		if (cpu_re)
			hold_word <= port_rd_hit ? port_rd_val : prom_data;
	end

	// RAM data only shows up on the valid cycle, so it bypasses the hold register
	assign cpu_rdata = sel_ram ? ram_rdata : hold_word;

endmodule

//--- hw/pvc_color_unpacker.sv
// PVC color unpacker
// Latches a packed palette color from port 0 and splits it into 5-bit
// blue, green and red components plus the dark bit for ports 1 and 2

module pvc_color_unpacker import pvc_pkg::*; (
	input  logic      CLK_24M,
	input  logic      nRESET,
	input  logic      port_we,
	input  pvc_port_t port_no,
	input  pvc_word_t port_wdata,
	output pvc_word_t unpack_bg,
	output pvc_word_t unpack_rs
);

	pvc_color_u color_q;
	logic [4:0] comp_b;
	logic [4:0] comp_g;
	logic [4:0] comp_r;
	pvc_color_u bg_u;
	pvc_color_u rs_u;

	// The written word is kept as a palette color
	always_ff @(posedge CLK_24M) begin
		if (!nRESET)
			color_q <= '0;
		else if (port_we && port_no == PORT_COLOR_IN)
			color_q.neo <= port_wdata;
	end

	// Each component gets its extra LSB from the top nibble of the color
	assign comp_b = {color_q.neo.blue,  color_q.neo.b_lsb};
	assign comp_g = {color_q.neo.green, color_q.neo.g_lsb};
	assign comp_r = {color_q.neo.red,   color_q.neo.r_lsb};

	// Green above blue on port 1, dark bit above red on port 2
	always_comb begin
		bg_u          = '0;
		bg_u.pair.hi  = comp_g;
		bg_u.pair.lo  = comp_b;
		rs_u          = '0;
		rs_u.pair.hi  = {4'b0000, color_q.neo.dark};
		rs_u.pair.lo  = comp_r;
	end

	assign unpack_bg = bg_u;
	assign unpack_rs = rs_u;

endmodule

//--- hw/pvc_color_packer.sv
// PVC color packer
// Collects 5-bit green and blue from port 4 and red from port 5, and
// presents them on port 6 as one palette color with the dark bit clear

module pvc_color_packer import pvc_pkg::*; (
	input  logic      CLK_24M,
	input  logic      nRESET,
	input  logic      port_we,
	input  pvc_port_t port_no,
	input  pvc_word_t port_wdata,
	output pvc_word_t pack_out
);

	pvc_color_u in_u;
	pvc_color_u out_u;
	logic [4:0] green_q;
	logic [4:0] blue_q;
	logic [4:0] red_q;

	// Incoming words carry one component in each byte
	assign in_u = port_wdata;

	always_ff @(posedge CLK_24M) begin
		if (!nRESET) begin
			green_q <= '0;
			blue_q  <= '0;
			red_q   <= '0;
		end else if (port_we) begin
			if (port_no == PORT_PACK_GB) begin
				green_q <= in_u.pair.hi;
				blue_q  <= in_u.pair.lo;
			end
			// Only the low component of port 5 is used
			if (port_no == PORT_PACK_R)
				red_q <= in_u.pair.lo;
		end
	end

	// Upper four bits go to the nibble fields, LSBs collect in bits 14 to 12
	always_comb begin
		out_u           = '0;
		out_u.neo.red   = red_q[4:1];
		out_u.neo.green = green_q[4:1];
		out_u.neo.blue  = blue_q[4:1];
		out_u.neo.r_lsb = red_q[0];
		out_u.neo.g_lsb = green_q[0];
		out_u.neo.b_lsb = blue_q[0];
	end

	assign pack_out = out_u;

endmodule

//--- hw/pvc_bank_map.sv
// PVC bank mapper
// Holds the 24-bit P2 bank offset written through ports 8 and 9 and adds
// it to the CPU byte address to form the P2 ROM address

module pvc_bank_map import pvc_pkg::*; (
	input  logic         CLK_24M,
	input  logic         nRESET,
	input  logic         enable,
	input  logic         port_we,
	input  pvc_port_t    port_no,
	input  pvc_word_t    port_wdata,
	input  pvc_waddr_t   cpu_addr,
	output pvc_word_t    bank_rd_lo,
	output pvc_word_t    bank_rd_hi,
	output pvc_p2_addr_t p2_addr
);

	// ======================================================================
	// Bank register
	// ======================================================================

	pvc_p2_addr_t bank;
	pvc_p2_addr_t bank_eff;

	// Bit 0 and bit 23 of the offset are forced to zero
	always_ff @(posedge CLK_24M) begin
		if (!nRESET) begin
			bank <= '0;
		end else if (port_we) begin
			if (port_no == PORT_BANK_LO)
				bank[7:0] <= {port_wdata[15:9], 1'b0};
			if (port_no == PORT_BANK_HI)
				bank[23:8] <= {1'b0, port_wdata[14:0]};
		end
	end

	// Low bank byte reads back in the upper lane with a fixed tag below it
	assign bank_rd_lo = {bank[7:0], BANK_LO_TAG};
	assign bank_rd_hi = bank[23:8];

	// ======================================================================
	// P2 address
	// ======================================================================

	// With the chip disabled the CPU address passes through unmapped
	assign bank_eff = enable ? bank : '0;
	assign p2_addr  = bank_eff + {4'b0000, cpu_addr, 1'b0};

endmodule

//--- hw/neo_pvc_top.sv
// NEO-PVC protection coprocessor top level
// Connects the bus decoder, the work RAM, the color unpacker and packer and
// the P2 bank mapper behind a synchronous 68000 side bus on CLK_24M

module neo_pvc_top import pvc_pkg::*; (
	input  logic         CLK_24M,
	input  logic         nRESET,
	input  logic         enable,
	input  pvc_waddr_t   cpu_addr,
	input  pvc_word_t    cpu_wdata,
	input  logic [1:0]   cpu_we,
	input  logic         cpu_re,
	input  pvc_word_t    prom_data,
	output pvc_word_t    cpu_rdata,
	output logic         cpu_rvalid,
	output pvc_p2_addr_t p2_addr
);

	// ======================================================================
	// Internal wiring
	// ======================================================================

	// Work RAM side
	pvc_ram_addr_t ram_addr;
	logic [1:0]    ram_we;
	pvc_word_t     ram_wdata;
	pvc_word_t     ram_rdata;

	// Port write bus shared by all protection blocks
	logic          port_we;
	pvc_port_t     port_no;
	pvc_word_t     port_wdata;

	// Port read values back to the decoder
	pvc_word_t     unpack_bg;
	pvc_word_t     unpack_rs;
	pvc_word_t     pack_out;
	pvc_word_t     bank_rd_lo;
	pvc_word_t     bank_rd_hi;

	// ======================================================================
	// Instances
	// ======================================================================

	pvc_bus_decode u_bus_decode (
		.CLK_24M    (CLK_24M),
		.nRESET     (nRESET),
		.enable     (enable),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cpu_we     (cpu_we),
		.cpu_re     (cpu_re),
		.prom_data  (prom_data),
		.ram_rdata  (ram_rdata),
		.unpack_bg  (unpack_bg),
		.unpack_rs  (unpack_rs),
		.pack_out   (pack_out),
		.bank_rd_lo (bank_rd_lo),
		.bank_rd_hi (bank_rd_hi),
		.cpu_rdata  (cpu_rdata),
		.cpu_rvalid (cpu_rvalid),
		.ram_addr   (ram_addr),
		.ram_we     (ram_we),
		.ram_wdata  (ram_wdata),
		.port_we    (port_we),
		.port_no    (port_no),
		.port_wdata (port_wdata)
	);

	pvc_work_ram u_work_ram (
		.CLK_24M   (CLK_24M),
		.ram_addr  (ram_addr),
		.ram_we    (ram_we),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

	pvc_color_unpacker u_color_unpacker (
		.CLK_24M    (CLK_24M),
		.nRESET     (nRESET),
		.port_we    (port_we),
		.port_no    (port_no),
		.port_wdata (port_wdata),
		.unpack_bg  (unpack_bg),
		.unpack_rs  (unpack_rs)
	);

	pvc_color_packer u_color_packer (
		.CLK_24M    (CLK_24M),
		.nRESET     (nRESET),
		.port_we    (port_we),
		.port_no    (port_no),
		.port_wdata (port_wdata),
		.pack_out   (pack_out)
	);

	// The mapper sees the raw CPU address, not the RAM index
	pvc_bank_map u_bank_map (
		.CLK_24M    (CLK_24M),
		.nRESET     (nRESET),
		.enable     (enable),
		.port_we    (port_we),
		.port_no    (port_no),
		.port_wdata (port_wdata),
		.cpu_addr   (cpu_addr),
		.bank_rd_lo (bank_rd_lo),
		.bank_rd_hi (bank_rd_hi),
		.p2_addr    (p2_addr)
	);

endmodule

//--- verification/tb_clock_gen.sv
// Testbench clock and reset source
// Makes CLK_24M with a period of 40 time units and holds nRESET low
// for the first three rising edges

module tb_clock_gen (
	output logic CLK_24M,
	output logic nRESET
);

	initial begin
		CLK_24M = 1'b0;
		forever #20 CLK_24M = ~CLK_24M;
	end

	// Reset is released on the third edge, so the DUT sees three reset cycles
	initial begin
		nRESET = 1'b0;
		repeat (3) @(posedge CLK_24M);
		nRESET <= 1'b1;
	end

endmodule

//--- verification/neo_pvc_assertions.sv
// Protocol checks for the PVC top level
// Watches the read handshake and the P2 address output of every
// neo_pvc_top instance through a bind

module neo_pvc_assertions import pvc_pkg::*; (
	input logic         CLK_24M,
	input logic         nRESET,
	input logic         cpu_re,
	input logic         cpu_rvalid,
	input pvc_p2_addr_t p2_addr
);

	// Number of assertion failures seen so far
	int fail_count = 0;

	// A read is answered on the next edge and never without a request
	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		1'b1 |=> (cpu_rvalid == $past(cpu_re)))
		else begin
			$error("cpu_rvalid does not follow cpu_re by one cycle");
			fail_count++;
		end

	// The valid flag is cleared by every reset edge
	assert property (@(posedge CLK_24M) !nRESET |=> !cpu_rvalid)
		else begin
			$error("cpu_rvalid high during reset");
			fail_count++;
		end

	// Bank bit 0 is forced low and the CPU byte address is even
	assert property (@(posedge CLK_24M) disable iff (!nRESET) !p2_addr[0])
		else begin
			$error("p2_addr bit 0 is set");
			fail_count++;
		end

endmodule

bind neo_pvc_top neo_pvc_assertions u_assertions (
	.CLK_24M    (CLK_24M),
	.nRESET     (nRESET),
	.cpu_re     (cpu_re),
	.cpu_rvalid (cpu_rvalid),
	.p2_addr    (p2_addr)
);

//--- verification/tb_neo_pvc.sv
// Testbench for the NEO-PVC protection coprocessor
// Directed tests over the work RAM, PROM passthrough, the color ports and
// the P2 bank mapper, each test printing one line when it finishes

module tb_neo_pvc import pvc_pkg::*; ();

	// Six tests take roughly 300 cycles, the limit leaves a wide margin
	localparam int MAX_CYCLES = 2000;

	logic         CLK_24M;
	logic         nRESET;
	logic         enable;
	pvc_waddr_t   cpu_addr;
	pvc_word_t    cpu_wdata;
	logic [1:0]   cpu_we;
	logic         cpu_re;
	pvc_word_t    prom_data;
	pvc_word_t    cpu_rdata;
	logic         cpu_rvalid;
	pvc_p2_addr_t p2_addr;

	int errors = 0;
	int checks = 0;
	int tests  = 0;
	int cycles = 0;

	// Last color of the unpacking test, packed again in the packing test
	pvc_word_t last_color;
	pvc_word_t last_bg;
	pvc_word_t last_rs;

	tb_clock_gen u_clock_gen (.CLK_24M(CLK_24M), .nRESET(nRESET));

	neo_pvc_top uut (.*);

	always @(posedge CLK_24M) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ======================================================================
	// Expected values
	// ======================================================================

	// Word address of a port at the top of the RAM window
	function automatic pvc_waddr_t port_addr(input pvc_port_t p);
		return {7'h7F, 8'hFF, p};
	endfunction

	// Green above blue, each with its extra LSB from bit 13 or 12
	function automatic pvc_word_t split_bg(input pvc_word_t c);
		return {3'b000, c[7:4], c[13], 3'b000, c[3:0], c[12]};
	endfunction

	// Dark bit above red
	function automatic pvc_word_t split_rs(input pvc_word_t c);
		return {7'b0000000, c[15], 3'b000, c[11:8], c[14]};
	endfunction

	function automatic pvc_word_t pack_color(input pvc_word_t gb, input pvc_word_t r);
		return {1'b0, r[0], gb[8], gb[0], r[4:1], gb[12:9], gb[4:1]};
	endfunction

	task automatic check_word(input string what, input pvc_word_t got, input pvc_word_t exp);
		checks++;
		if (got !== exp) begin
			$display("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_p2_addr(input string what, input pvc_p2_addr_t got,
			input pvc_p2_addr_t exp);
		checks++;
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests++;
		if (errors == start_errors)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - start_errors);
	endtask

	// ======================================================================
	// Bus cycles
	// ======================================================================

	// The write lands on the edge where the next bus cycle is driven
	task automatic write_word(input pvc_waddr_t addr, input pvc_word_t data,
			input logic [1:0] we);
		@(posedge CLK_24M);
		cpu_addr  <= addr;
		cpu_wdata <= data;
		cpu_we    <= we;
		cpu_re    <= 1'b0;
	endtask

	task automatic set_enable(input logic en);
		@(posedge CLK_24M);
		enable <= en;
		cpu_we <= 2'b00;
		cpu_re <= 1'b0;
	endtask

	task automatic require_valid(input pvc_waddr_t addr);
		if (cpu_rvalid !== 1'b1) begin
			$display("Read of address %h was not answered with cpu_rvalid", addr);
			errors++;
		end
	endtask

	// Each read offers a fresh random PROM word so the mux choice is visible
	task automatic read_word(input pvc_waddr_t addr, output pvc_word_t data,
			output pvc_word_t prom);
		prom = pvc_word_t'($urandom);
		@(posedge CLK_24M);
		cpu_addr  <= addr;
		cpu_we    <= 2'b00;
		cpu_re    <= 1'b1;
		prom_data <= prom;
		@(posedge CLK_24M);
		cpu_re <= 1'b0;
		@(negedge CLK_24M);
		require_valid(addr);
		data = cpu_rdata;
	endtask

	// Two requests on consecutive edges, answers on consecutive cycles
	task automatic read_pair(input pvc_waddr_t a0, input pvc_waddr_t a1,
			output pvc_word_t d0, output pvc_word_t d1);
		@(posedge CLK_24M);
		cpu_addr <= a0;
		cpu_we   <= 2'b00;
		cpu_re   <= 1'b1;
		@(posedge CLK_24M);
		cpu_addr <= a1;
		@(negedge CLK_24M);
		require_valid(a0);
		d0 = cpu_rdata;
		@(posedge CLK_24M);
		cpu_re <= 1'b0;
		@(negedge CLK_24M);
		require_valid(a1);
		d1 = cpu_rdata;
	endtask

	task automatic probe_p2(input pvc_waddr_t addr, input pvc_p2_addr_t exp);
		@(posedge CLK_24M);
		cpu_addr <= addr;
		cpu_we   <= 2'b00;
		@(negedge CLK_24M);
		check_p2_addr($sformatf("p2_addr for %h", addr), p2_addr, exp);
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic ram_round_trip();
		int         start;
		pvc_waddr_t addr [8];
		pvc_word_t  exp [8];
		pvc_word_t  base;
		pvc_word_t  upd;
		pvc_word_t  d0;
		pvc_word_t  d1;
		pvc_word_t  prom;
		logic [1:0] we;
		start = errors;
		for (int i = 0; i < 8; i++) begin
			// Rows 30 apart keep the words distinct and below the port row
			addr[i] = {7'h7F, 8'(i * 30 + $urandom_range(29)), 4'($urandom)};
			base    = pvc_word_t'($urandom);
			upd     = pvc_word_t'($urandom);
			we      = 2'(i);
			exp[i]  = {we[1] ? upd[15:8] : base[15:8], we[0] ? upd[7:0] : base[7:0]};
			write_word(addr[i], base, 2'b11);
			write_word(addr[i], upd, we);
			read_word(addr[i], d0, prom);
			check_word($sformatf("RAM %h", addr[i]), d0, exp[i]);
		end
		for (int i = 0; i < 8; i += 2) begin
			read_pair(addr[i], addr[i + 1], d0, d1);
			check_word($sformatf("RAM pair %h", addr[i]), d0, exp[i]);
			check_word($sformatf("RAM pair %h", addr[i + 1]), d1, exp[i + 1]);
		end
		report_test("RAM round trip", start);
	endtask

	task automatic prom_and_disable();
		int         start;
		pvc_waddr_t addr;
		pvc_word_t  keep;
		pvc_word_t  data;
		pvc_word_t  prom;
		start = errors;
		// Top address bits below all ones fall outside the RAM window
		for (int i = 0; i < 4; i++) begin
			addr = {7'($urandom_range(126)), 12'($urandom)};
			read_word(addr, data, prom);
			check_word($sformatf("PROM %h", addr), data, prom);
		end
		addr = {7'h7F, 12'h5A3};
		keep = pvc_word_t'($urandom);
		write_word(addr, keep, 2'b11);
		set_enable(1'b0);
		write_word(addr, ~keep, 2'b11);
		// The bank test later expects this write to have been dropped
		write_word(port_addr(PORT_BANK_LO), 16'hFFFF, 2'b11);
		read_word(addr, data, prom);
		check_word("disabled RAM read", data, prom);
		read_word(port_addr(PORT_UNPACK_BG), data, prom);
		check_word("disabled port read", data, prom);
		set_enable(1'b1);
		read_word(addr, data, prom);
		check_word("RAM after disabled write", data, keep);
		report_test("PROM passthrough and disable", start);
	endtask

	task automatic color_unpacking();
		int        start;
		pvc_word_t prom;
		start = errors;
		for (int i = 0; i < 8; i++) begin
			last_color = pvc_word_t'($urandom);
			write_word(port_addr(PORT_COLOR_IN), last_color, 2'b11);
			read_word(port_addr(PORT_UNPACK_BG), last_bg, prom);
			check_word($sformatf("port 1 for %h", last_color), last_bg, split_bg(last_color));
			read_word(port_addr(PORT_UNPACK_RS), last_rs, prom);
			check_word($sformatf("port 2 for %h", last_color), last_rs, split_rs(last_color));
		end
		report_test("Color unpacking", start);
	endtask

	task automatic color_packing();
		int        start;
		pvc_word_t gb;
		pvc_word_t r;
		pvc_word_t data;
		pvc_word_t prom;
		start = errors;
		for (int i = 0; i < 4; i++) begin
			gb = pvc_word_t'($urandom);
			r  = pvc_word_t'($urandom);
			write_word(port_addr(PORT_PACK_GB), gb, 2'b11);
			write_word(port_addr(PORT_PACK_R), r, 2'b11);
			read_word(port_addr(PORT_PACK_OUT), data, prom);
			check_word($sformatf("port 6 for %h %h", gb, r), data, pack_color(gb, r));
		end
		// The unpacked components rebuild the color without its dark bit
		write_word(port_addr(PORT_PACK_GB), last_bg, 2'b11);
		write_word(port_addr(PORT_PACK_R), last_rs, 2'b11);
		read_word(port_addr(PORT_PACK_OUT), data, prom);
		check_word("repacked color", data, {1'b0, last_color[14:0]});
		report_test("Color packing", start);
	endtask

	task automatic bank_mapping();
		int           start;
		pvc_p2_addr_t bank;
		pvc_waddr_t   addr;
		pvc_word_t    lo;
		pvc_word_t    hi;
		pvc_word_t    data;
		pvc_word_t    prom;
		start = errors;
		// No enabled write has reached the bank since reset
		bank = '0;
		for (int i = 0; i < 5; i++) begin
			if (i > 0) begin
				lo = pvc_word_t'($urandom);
				hi = pvc_word_t'($urandom);
				write_word(port_addr(PORT_BANK_LO), lo, 2'b11);
				write_word(port_addr(PORT_BANK_HI), hi, 2'b11);
				bank = {1'b0, hi[14:0], lo[15:9], 1'b0};
			end
			read_word(port_addr(PORT_BANK_LO), data, prom);
			check_word("port 8", data, {bank[7:0], 8'hA0});
			read_word(port_addr(PORT_BANK_HI), data, prom);
			check_word("port 9", data, bank[23:8]);
			addr = pvc_waddr_t'($urandom);
			probe_p2(addr, bank + {4'b0000, addr, 1'b0});
			set_enable(1'b0);
			probe_p2(addr, {4'b0000, addr, 1'b0});
			set_enable(1'b1);
		end
		report_test("Bank mapping", start);
	endtask

	task automatic port_overlay();
		int        start;
		pvc_word_t w;
		pvc_word_t data;
		pvc_word_t prom;
		start = errors;
		w = pvc_word_t'($urandom);
		write_word(port_addr(4'd3), w, 2'b11);
		read_word(port_addr(4'd3), data, prom);
		check_word("unmapped port 3", data, w);
		// Port 0 has no read value of its own, so the RAM word shows through
		w = pvc_word_t'($urandom);
		write_word(port_addr(PORT_COLOR_IN), w, 2'b11);
		read_word(port_addr(PORT_COLOR_IN), data, prom);
		check_word("port 0 read", data, w);
		report_test("Port overlay on RAM", start);
	endtask

	// ======================================================================
	// Sequence
	// ======================================================================

	initial begin
		void'($urandom(87));
		enable    = 1'b1;
		cpu_addr  = '0;
		cpu_wdata = '0;
		cpu_we    = 2'b00;
		cpu_re    = 1'b0;
		prom_data = '0;
		@(posedge CLK_24M);
		while (nRESET !== 1'b1)
			@(posedge CLK_24M);
		ram_round_trip();
		prom_and_disable();
		color_unpacking();
		color_packing();
		bank_mapping();
		port_overlay();
		$display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
			tests, checks, errors, uut.u_assertions.fail_count);
		if (errors == 0 && uut.u_assertions.fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- tb.f
hw/pvc_pkg.sv
hw/pvc_work_ram.sv
hw/pvc_bus_decode.sv
hw/pvc_color_unpacker.sv
hw/pvc_color_packer.sv
hw/pvc_bank_map.sv
hw/neo_pvc_top.sv
verification/tb_clock_gen.sv
verification/neo_pvc_assertions.sv
verification/tb_neo_pvc.sv

//--- Bender.yml
package:
  name: neo_pvc

sources:
  - files:
      - hw/pvc_pkg.sv
      - hw/pvc_work_ram.sv
      - hw/pvc_bus_decode.sv
      - hw/pvc_color_unpacker.sv
      - hw/pvc_color_packer.sv
      - hw/pvc_bank_map.sv
      - hw/neo_pvc_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/neo_pvc_assertions.sv
      - verification/tb_neo_pvc.sv
